// ==== design/video_pkg.sv ====
////////////////////////////////////////
// video timing types
// counts, positions and bar layout.
////////////////////////////////////////
`default_nettype none

package video_pkg;

    // bits in every count and position.
    localparam int COUNT_WIDTH = 16;

    // pixels, lines, blank lengths and positions.
    typedef logic [COUNT_WIDTH-1:0] count_t;

    ////////////////////////////////////////
    // bar layout
    ////////////////////////////////////////
    localparam int BAR_COUNT     = 8;                  // bars across one line.
    localparam int BAR_IDX_WIDTH = $clog2(BAR_COUNT);  // bits of the bar number.

    // bar number within a line, wraps after BAR_COUNT.
    typedef logic [BAR_IDX_WIDTH-1:0] bar_idx_t;

endpackage

`default_nettype wire

// ==== design/pattern_pkg.sv ====
////////////////////////////////////////
// pattern types
// output modes of the pattern mixer.
////////////////////////////////////////
`default_nettype none

package pattern_pkg;

    localparam int MODE_WIDTH = 2;

    // what the mixer puts on do_o for one frame.
    typedef enum logic [MODE_WIDTH-1:0] {
        MODE_RAMP  = 2'd0,  // ramp only.
        MODE_BARS  = 2'd1,  // bars only.
        MODE_BLEND = 2'd2,  // mean of ramp and bars, rounded down.
        MODE_BLACK = 2'd3   // all zeros.
    } mode_t;

    // mode in force from reset until the first vertical blank ends.
    localparam mode_t MODE_RESET = MODE_RAMP;

endpackage

`default_nettype wire

// ==== design/video_timing_gen.sv ====
////////////////////////////////////////
// video timing generator
// frame FSM, sync strobes and pixel/line position.
////////////////////////////////////////
`default_nettype none

module video_timing_gen (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire  video_pkg::count_t   pix_count_i,
    input  wire  video_pkg::count_t   line_count_i,
    input  wire  video_pkg::count_t   hs_count_i,
    input  wire  video_pkg::count_t   vs_count_i,
    output logic                      de_o,
    output logic                      hs_o,
    output logic                      vs_o,
    output video_pkg::count_t         x_o,
    output video_pkg::count_t         y_o
);

    typedef enum logic [1:0] {
        HBLANK,
        ACTIVE,
        VBLANK
    } state_t;

    state_t state_q;

    video_pkg::count_t h_cnt_q;     // cycle within the current segment.
    video_pkg::count_t v_cnt_q;     // active line number.

    // shadow copies so one frame never mixes two settings.
    video_pkg::count_t pix_q;
    video_pkg::count_t line_q;
    video_pkg::count_t hs_len_q;
    video_pkg::count_t vs_len_q;

    // last index of each segment.
    video_pkg::count_t pix_last;
    video_pkg::count_t line_last;
    video_pkg::count_t hs_last;
    video_pkg::count_t vs_last;

    logic frame_end;                // last cycle of the vertical blank.

    assign pix_last  = video_pkg::count_t'(pix_q - 1'b1);
    assign line_last = video_pkg::count_t'(line_q - 1'b1);
    assign hs_last   = video_pkg::count_t'(hs_len_q - 1'b1);
    assign vs_last   = video_pkg::count_t'(vs_len_q - 1'b1);

    assign frame_end = (state_q == VBLANK) && (h_cnt_q == vs_last);

    ////////////////////////////////////////
    // count shadows
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i || frame_end) begin
            pix_q    <= pix_count_i;
            line_q   <= line_count_i;
            hs_len_q <= hs_count_i;
            vs_len_q <= vs_count_i;
        end
    end

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= HBLANK;              // frame opens with a line blank.
            h_cnt_q <= '0;
            v_cnt_q <= '0;
            de_o    <= 1'b0;
            hs_o    <= 1'b1;                // strobes track the state.
            vs_o    <= 1'b0;
        end else begin
            case (state_q)
                HBLANK: begin
                    if (h_cnt_q == hs_last) begin
                        h_cnt_q <= '0;
                        hs_o    <= 1'b0;
                        de_o    <= 1'b1;
                        state_q <= ACTIVE;
                    end else begin
                        h_cnt_q <= h_cnt_q + 1'b1;
                    end
                end

                ACTIVE: begin
                    if (h_cnt_q == pix_last) begin
                        h_cnt_q <= '0;
                        de_o    <= 1'b0;
                        if (v_cnt_q == line_last) begin
                            v_cnt_q <= '0;
                            vs_o    <= 1'b1;    // last line done.
                            state_q <= VBLANK;
                        end else begin
                            v_cnt_q <= v_cnt_q + 1'b1;
                            hs_o    <= 1'b1;
                            state_q <= HBLANK;
                        end
                    end else begin
                        h_cnt_q <= h_cnt_q + 1'b1;
                    end
                end

                VBLANK: begin
                    if (frame_end) begin
                        h_cnt_q <= '0;
                        vs_o    <= 1'b0;
                        hs_o    <= 1'b1;        // next frame starts.
                        state_q <= HBLANK;
                    end else begin
                        h_cnt_q <= h_cnt_q + 1'b1;
                    end
                end

                default: begin
                    h_cnt_q <= '0;
                    v_cnt_q <= '0;
                    de_o    <= 1'b0;
                    hs_o    <= 1'b1;
                    vs_o    <= 1'b0;
                    state_q <= HBLANK;
                end
            endcase
        end
    end

    // x is only meaningful while de_o is high.
    assign x_o = h_cnt_q;
    assign y_o = v_cnt_q;

endmodule

`default_nettype wire

// ==== design/ramp_pattern.sv ====
////////////////////////////////////////
// ramp pattern
// odd pixels carry their index, even ones mid-gray.
////////////////////////////////////////
`default_nettype none

module ramp_pattern #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      de_i,
    input  wire  video_pkg::count_t  x_i,
    output logic [PIXEL_WIDTH-1:0]   ramp_o
);

    localparam logic [PIXEL_WIDTH-1:0] MID_GRAY = 1'b1 << (PIXEL_WIDTH - 1);

    logic [PIXEL_WIDTH-1:0] ramp_d;

    // pixel for the current position.
    always_comb begin
        if (!de_i) begin
            ramp_d = '0;                     // blanking stays black.
        end else if (x_i[0]) begin
            ramp_d = x_i[PIXEL_WIDTH-1:0];   // low bits of the index.
        end else begin
            ramp_d = MID_GRAY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ramp_o <= '0;
        end else begin
            ramp_o <= ramp_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/bar_pattern.sv ====
////////////////////////////////////////
// bar pattern
// eight grey bars of run-time width.
////////////////////////////////////////
`default_nettype none

module bar_pattern #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      de_i,
    input  wire  video_pkg::count_t  x_i,
    input  wire  video_pkg::count_t  bar_width_i,
    output logic [PIXEL_WIDTH-1:0]   bar_o
);

    localparam int SHIFT = PIXEL_WIDTH - video_pkg::BAR_IDX_WIDTH;
    localparam video_pkg::bar_idx_t LAST_BAR =
        video_pkg::bar_idx_t'(video_pkg::BAR_COUNT - 1);

    // state held for the following pixel.
    video_pkg::count_t   cnt_q;      // pixels done in the current bar.
    video_pkg::bar_idx_t idx_q;
    video_pkg::count_t   width_q;    // bar width for this line.

    // state seen by the current pixel.
    video_pkg::count_t   cur_cnt;
    video_pkg::bar_idx_t cur_idx;
    video_pkg::count_t   cur_width;
    logic                line_start;
    logic                bar_end;

    assign line_start = de_i && (x_i == '0);

    // first pixel of a line restarts the count and picks up the width.
    assign cur_cnt   = line_start ? '0 : cnt_q;
    assign cur_idx   = line_start ? '0 : idx_q;
    assign cur_width = line_start ? bar_width_i : width_q;

    assign bar_end = (cur_cnt == video_pkg::count_t'(cur_width - 1'b1));

    ////////////////////////////////////////
    // bar counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q   <= '0;
            idx_q   <= '0;
        end else if (de_i) begin
            if (bar_end) begin
                cnt_q <= '0;
                idx_q <= (cur_idx == LAST_BAR) ? '0 : cur_idx + 1'b1;  // wrap.
            end else begin
                cnt_q <= cur_cnt + 1'b1;
                idx_q <= cur_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            width_q <= bar_width_i;      // held for the rest of the line.
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bar_o <= '0;
        end else if (de_i) begin
            bar_o <= {cur_idx, {SHIFT{1'b0}}};  // index scaled to full range.
        end else begin
            bar_o <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/pattern_mixer.sv ====
////////////////////////////////////////
// pattern mixer
// per-frame pattern select and sync alignment.
////////////////////////////////////////
`default_nettype none

module pattern_mixer #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        de_i,
    input  wire                        hs_i,
    input  wire                        vs_i,
    input  wire  pattern_pkg::mode_t   mode_i,
    input  wire  [PIXEL_WIDTH-1:0]     ramp_i,
    input  wire  [PIXEL_WIDTH-1:0]     bar_i,
    output logic [PIXEL_WIDTH-1:0]     do_o,
    output logic                       de_o,
    output logic                       hs_o,
    output logic                       vs_o
);

    // first delay stage, level with the pattern pixels.
    logic de_d1_q;
    logic hs_d1_q;
    logic vs_d1_q;

    pattern_pkg::mode_t mode_q;     // mode of the frame on the outputs.

    logic                   vs_fall;
    logic [PIXEL_WIDTH:0]   blend_sum;
    logic [PIXEL_WIDTH-1:0] pix_sel;

    // output vs drops on the next edge.
    assign vs_fall = vs_o && !vs_d1_q;

    assign blend_sum = {1'b0, ramp_i} + {1'b0, bar_i};

    always_comb begin
        case (mode_q)
            pattern_pkg::MODE_RAMP:  pix_sel = ramp_i;
            pattern_pkg::MODE_BARS:  pix_sel = bar_i;
            pattern_pkg::MODE_BLEND: pix_sel = blend_sum[PIXEL_WIDTH:1];  // mean.
            default:                 pix_sel = '0;
        endcase
    end

    ////////////////////////////////////////
    // sync delay line
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_d1_q <= 1'b0;
            hs_d1_q <= 1'b0;
            vs_d1_q <= 1'b0;
            de_o    <= 1'b0;
            hs_o    <= 1'b0;
            vs_o    <= 1'b0;
        end else begin
            de_d1_q <= de_i;
            hs_d1_q <= hs_i;
            vs_d1_q <= vs_i;
            de_o    <= de_d1_q;
            hs_o    <= hs_d1_q;
            vs_o    <= vs_d1_q;
        end
    end

    // one mode per frame, taken as the vertical blank closes.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mode_q <= pattern_pkg::MODE_RESET;
        end else if (vs_fall) begin
            mode_q <= mode_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            do_o <= '0;
        end else begin
            do_o <= de_d1_q ? pix_sel : '0;   // black outside active video.
        end
    end

endmodule

`default_nettype wire

// ==== design/video_pattern_top.sv ====
////////////////////////////////////////
// video test-pattern source
// timing, ramp and bar patterns, mixer.
////////////////////////////////////////
`default_nettype none

module video_pattern_top #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire  video_pkg::count_t    pix_count_i,
    input  wire  video_pkg::count_t    line_count_i,
    input  wire  video_pkg::count_t    hs_count_i,
    input  wire  video_pkg::count_t    vs_count_i,
    input  wire  video_pkg::count_t    bar_width_i,
    input  wire  pattern_pkg::mode_t   mode_i,
    output logic [PIXEL_WIDTH-1:0]     do_o,
    output logic                       de_o,
    output logic                       hs_o,
    output logic                       vs_o
);

    logic                   de;
    logic                   hs;
    logic                   vs;
    video_pkg::count_t      x;
    logic [PIXEL_WIDTH-1:0] ramp_pix;
    logic [PIXEL_WIDTH-1:0] bar_pix;

    video_timing_gen video_timing_gen_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .pix_count_i  (pix_count_i),
        .line_count_i (line_count_i),
        .hs_count_i   (hs_count_i),
        .vs_count_i   (vs_count_i),
        .de_o         (de),
        .hs_o         (hs),
        .vs_o         (vs),
        .x_o          (x),
        .y_o          ()
    );

    ramp_pattern #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) ramp_pattern_i (
        .clk     (clk),
        .reset_i (reset_i),
        .de_i    (de),
        .x_i     (x),
        .ramp_o  (ramp_pix)
    );

    bar_pattern #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) bar_pattern_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .de_i        (de),
        .x_i         (x),
        .bar_width_i (bar_width_i),
        .bar_o       (bar_pix)
    );

    pattern_mixer #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) pattern_mixer_i (
        .clk     (clk),
        .reset_i (reset_i),
        .de_i    (de),
        .hs_i    (hs),
        .vs_i    (vs),
        .mode_i  (mode_i),
        .ramp_i  (ramp_pix),
        .bar_i   (bar_pix),
        .do_o    (do_o),
        .de_o    (de_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

endmodule

`default_nettype wire

// ==== test/video_pattern_tb.sv ====
////////////////////////////////////////
// video pattern testbench
// table-driven frames against a reference model.
////////////////////////////////////////
`default_nettype none

module video_pattern_tb;

    localparam int PIXEL_WIDTH = 8;
    localparam int ROWS        = 6;

    // table columns.
    localparam int C_PIX    = 0;
    localparam int C_LINES  = 1;
    localparam int C_HS     = 2;
    localparam int C_VS     = 3;
    localparam int C_BW     = 4;
    localparam int C_PERIOD = 5;

    logic                   clk;
    logic                   reset_i;
    video_pkg::count_t      pix_count_i;
    video_pkg::count_t      line_count_i;
    video_pkg::count_t      hs_count_i;
    video_pkg::count_t      vs_count_i;
    video_pkg::count_t      bar_width_i;
    pattern_pkg::mode_t     mode_i;
    logic [PIXEL_WIDTH-1:0] do_o;
    logic                   de_o;
    logic                   hs_o;
    logic                   vs_o;

    int                 tbl [ROWS][6];
    pattern_pkg::mode_t tbl_mode [ROWS];

    int   errors      = 0;
    int   row_errors  = 0;
    int   cycle_count = 0;
    int   limit       = 0;
    int   row         = 0;          // frame under check.
    int   now         = 0;
    int   x           = 0;          // rebuilt pixel position.
    int   y           = 0;          // rebuilt line number.
    int   frame_len   = 0;
    int   de_total    = 0;
    int   hs_run      = 0;
    int   hs_runs     = 0;
    int   vs_run      = 0;
    int   last_rise   = 0;
    logic started     = 1'b0;
    logic prev_de     = 1'b0;
    logic prev_hs     = 1'b0;
    logic prev_vs     = 1'b0;

    video_pattern_top #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) video_pattern_top_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .pix_count_i  (pix_count_i),
        .line_count_i (line_count_i),
        .hs_count_i   (hs_count_i),
        .vs_count_i   (vs_count_i),
        .bar_width_i  (bar_width_i),
        .mode_i       (mode_i),
        .do_o         (do_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (limit > 0 && cycle_count >= limit) begin
            $display("timeout: the table did not finish within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic load_row(input int r, input int pix, input int lines, input int hs,
                            input int vs, input int bw, input pattern_pkg::mode_t mode,
                            input int period);
        tbl[r][C_PIX]    = pix;
        tbl[r][C_LINES]  = lines;
        tbl[r][C_HS]     = hs;
        tbl[r][C_VS]     = vs;
        tbl[r][C_BW]     = bw;
        tbl[r][C_PERIOD] = period;
        tbl_mode[r]      = mode;
    endtask

    task automatic drive_row(input int r);
        pix_count_i  <= video_pkg::count_t'(tbl[r][C_PIX]);
        line_count_i <= video_pkg::count_t'(tbl[r][C_LINES]);
        hs_count_i   <= video_pkg::count_t'(tbl[r][C_HS]);
        vs_count_i   <= video_pkg::count_t'(tbl[r][C_VS]);
        bar_width_i  <= video_pkg::count_t'(tbl[r][C_BW]);
        mode_i       <= tbl_mode[r];
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic outputs_idle();
        compare("do_o", do_o, 0);
        compare("de_o", de_o, 0);
        compare("hs_o", hs_o, 0);
        compare("vs_o", vs_o, 0);
    endtask

    // the first frame after reset always shows the ramp.
    function automatic pattern_pkg::mode_t frame_mode(input int r);
        return (r == 0) ? pattern_pkg::MODE_RAMP : tbl_mode[r];
    endfunction

    function automatic int pixel_model(input pattern_pkg::mode_t mode, input int px, input int bw);
        int ramp;
        int bars;
        int pix;
        ramp = (px % 2 == 1) ? px % (1 << PIXEL_WIDTH) : 1 << (PIXEL_WIDTH - 1);
        bars = ((px / bw) % video_pkg::BAR_COUNT) << (PIXEL_WIDTH - 3);
        case (mode)
            pattern_pkg::MODE_RAMP:  pix = ramp;
            pattern_pkg::MODE_BARS:  pix = bars;
            pattern_pkg::MODE_BLEND: pix = (ramp + bars) / 2;   // rounded down.
            default:                 pix = 0;
        endcase
        return pix;
    endfunction

    task automatic close_frame();
        compare("vs_o run", vs_run, tbl[row][C_VS]);
        compare("hs_o runs", hs_runs, tbl[row][C_LINES]);
        compare("active lines", y, tbl[row][C_LINES]);
        compare("de_o cycles", de_total, tbl[row][C_PIX] * tbl[row][C_LINES]);
        compare("frame period", frame_len, tbl[row][C_PERIOD]);
        $display("row %0d: mode %0d, %0d cycles, %0d errors",
                 row, int'(frame_mode(row)), frame_len, row_errors);
        row++;
        row_errors = 0;
        frame_len  = 0;
        de_total   = 0;
        hs_runs    = 0;
        hs_run     = 0;
        vs_run     = 0;
        x          = 0;
        y          = 0;
    endtask

    ////////////////////////////////////////
    // stimulus and checking
    ////////////////////////////////////////
    initial begin
        reset_i      = 1'b1;
        pix_count_i  = '0;
        line_count_i = '0;
        hs_count_i   = '0;
        vs_count_i   = '0;
        bar_width_i  = '0;
        mode_i       = pattern_pkg::MODE_RAMP;
        //       row pix lines hs vs bw  mode                     period
        load_row(0,  16, 3,    2, 4, 2,  pattern_pkg::MODE_BARS,  58);   // reset mode wins.
        load_row(1,  12, 2,    1, 5, 1,  pattern_pkg::MODE_BARS,  31);   // one-pixel bars.
        load_row(2,  40, 2,    3, 4, 3,  pattern_pkg::MODE_BLEND, 90);   // bars wrap.
        load_row(3,  20, 3,    2, 6, 2,  pattern_pkg::MODE_BLACK, 72);
        load_row(4,  300, 1,   1, 4, 7,  pattern_pkg::MODE_RAMP,  305);  // x past 8 bits.
        load_row(5,  50, 2,    4, 7, 5,  pattern_pkg::MODE_BARS,  115);
        for (int r = 0; r < ROWS; r++) begin
            limit += tbl[r][C_PERIOD];
        end
        limit = 2 * limit + 100;

        @(posedge clk);
        drive_row(0);
        repeat (4) begin
            @(posedge clk);
            outputs_idle();
        end
        reset_i <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            outputs_idle();                 // still quiet just after reset.
        end

        while (row < ROWS) begin
            @(posedge clk);
            now++;
            if (int'(de_o) + int'(hs_o) + int'(vs_o) > 1) begin
                $display("de_o, hs_o and vs_o are high together at cycle %0d", now);
                errors++;
                row_errors++;
            end
            if (!de_o) begin
                compare("do_o", do_o, 0);
            end
            if (prev_vs && !vs_o) begin
                close_frame();
            end
            if (hs_o) begin
                started = 1'b1;
            end
            if (started) begin
                frame_len++;
            end
            if (de_o && row < ROWS) begin
                compare("do_o", do_o, pixel_model(frame_mode(row), x, tbl[row][C_BW]));
                x++;
                de_total++;
            end else if (prev_de && row < ROWS) begin
                compare("de_o run", x, tbl[row][C_PIX]);
                x = 0;
                y++;
            end
            if (hs_o) begin
                hs_run++;
            end else if (prev_hs && row < ROWS) begin
                compare("hs_o run", hs_run, tbl[row][C_HS]);
                hs_run = 0;
                hs_runs++;
            end
            if (vs_o) begin
                vs_run++;
            end
            if (vs_o && !prev_vs && row < ROWS) begin
                if (row > 0) begin
                    compare("vs_o rise spacing", now - last_rise,
                            tbl[row-1][C_VS] + tbl[row][C_PERIOD] - tbl[row][C_VS]);
                end
                last_rise = now;
                if (row + 1 < ROWS) begin
                    drive_row(row + 1);     // new settings wait for the next frame.
                end
            end
            prev_de = de_o;
            prev_hs = hs_o;
            prev_vs = vs_o;
        end

        $display("rows %0d, cycles %0d, errors %0d", ROWS, now, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/video_pkg.sv
design/pattern_pkg.sv
design/video_timing_gen.sv
design/ramp_pattern.sv
design/bar_pattern.sv
design/pattern_mixer.sv
design/video_pattern_top.sv
test/video_pattern_tb.sv
